// File: src/id_pkg.sv
//////////////////////////////////////////////////
// Shared definitions for the RV32I decode stage
// Widths, instruction fields, opcodes, mux enums
// and the pipeline structs around ID
// Imported by every block of the stage
//////////////////////////////////////////////////
package id_pkg;

  //////////////////////////////////////////////////
  // Widths and instruction fields
  //////////////////////////////////////////////////

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  // Register index positions in the instruction word
  localparam int REG_S1_MSB = 19;
  localparam int REG_S1_LSB = 15;
  localparam int REG_S2_MSB = 24;
  localparam int REG_S2_LSB = 20;
  localparam int REG_D_MSB  = 11;
  localparam int REG_D_LSB  = 7;

  // Link value offset, no compressed support
  localparam int PC_INCR = 4;

  // Major opcodes of the decoded subset
  localparam logic [6:0] OPC_OP     = 7'h33;
  localparam logic [6:0] OPC_OPIMM  = 7'h13;
  localparam logic [6:0] OPC_LUI    = 7'h37;
  localparam logic [6:0] OPC_AUIPC  = 7'h17;
  localparam logic [6:0] OPC_JAL    = 7'h6f;
  localparam logic [6:0] OPC_JALR   = 7'h67;
  localparam logic [6:0] OPC_BRANCH = 7'h63;

  //////////////////////////////////////////////////
  // Base types and mux selects
  //////////////////////////////////////////////////

  typedef logic [XLEN-1:0]       data_t;
  typedef logic [REG_ADDR_W-1:0] rf_addr_t;

  // ALU operations, compares last
  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_opcode_e;

  // Forwarding source for rs1/rs2
  typedef enum logic [1:0] {FW_REGFILE, FW_EX, FW_WB} fw_sel_e;

  // JALR base only forwards from WB
  typedef enum logic {JFW_REGFILE, JFW_WB} jalr_fw_sel_e;

  typedef enum logic [1:0] {OPA_NONE, OPA_REG, OPA_PC, OPA_ZERO} op_a_sel_e;
  typedef enum logic [1:0] {OPB_NONE, OPB_REG, OPB_IMM} op_b_sel_e;
  typedef enum logic [1:0] {OPC_NONE, OPC_REG, OPC_BCH} op_c_sel_e;
  typedef enum logic [1:0] {IMMB_I, IMMB_S, IMMB_U, IMMB_PCINCR} imm_b_sel_e;
  typedef enum logic [1:0] {BJ_JAL, BJ_JALR, BJ_BCH} bch_jmp_sel_e;

  //////////////////////////////////////////////////
  // Pipeline and control structs
  //////////////////////////////////////////////////

  typedef struct packed {
    logic  instr_valid;
    data_t pc;
    data_t instr;
  } if_id_pipe_t;

  // Bypass selects from the controller
  typedef struct packed {
    fw_sel_e      op_a_fw_sel;
    fw_sel_e      op_b_fw_sel;
    jalr_fw_sel_e jalr_fw_sel;
  } ctrl_byp_t;

  typedef struct packed {
    logic kill_id;
    logic halt_id;
  } ctrl_fsm_t;

  // Sign extended immediates of every format
  typedef struct packed {
    data_t i;
    data_t s;
    data_t sb;
    data_t u;
    data_t uj;
  } imm_set_t;

  // Decoder control word
  typedef struct packed {
    logic         alu_en;
    logic         alu_bch;
    logic         alu_jmp;
    alu_opcode_e  alu_operator;
    op_a_sel_e    op_a_sel;
    op_b_sel_e    op_b_sel;
    op_c_sel_e    op_c_sel;
    imm_b_sel_e   imm_b_sel;
    bch_jmp_sel_e bch_jmp_sel;
    logic [1:0]   rf_re;
    logic         rf_we;
    rf_addr_t     rf_waddr;
    logic         illegal_insn;
  } dec_ctrl_t;

  typedef struct packed {
    data_t operand_a;
    data_t operand_b;
    data_t operand_c;
    data_t jalr_fw;
  } operands_t;

  typedef struct packed {
    logic        instr_valid;
    logic        alu_en;
    logic        alu_bch;
    logic        alu_jmp;
    alu_opcode_e alu_operator;
    data_t       alu_operand_a;
    data_t       alu_operand_b;
    data_t       operand_c;
    logic        rf_we;
    rf_addr_t    rf_waddr;
    logic        illegal_insn;
    data_t       pc;
    data_t       instr;
  } id_ex_pipe_t;

endpackage

// File: src/id_decoder.sv
//////////////////////////////////////////////////
// RV32I decoder for OP, OP-IMM, LUI, AUIPC,
// JAL, JALR and branches
// Produces the control word and all immediates
// Purely combinational
//////////////////////////////////////////////////
`timescale 1ns/100ps

module id_decoder (
  input  id_pkg::data_t     instr_i,
  output id_pkg::dec_ctrl_t dec_o,
  output id_pkg::imm_set_t  imm_o
);
  import id_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  rf_addr_t   rd;
  dec_ctrl_t  dec;
  logic       illegal;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  assign rd     = instr_i[REG_D_MSB:REG_D_LSB];

  //////////////////////////////////////////////////
  // Immediate extraction
  //////////////////////////////////////////////////

  assign imm_o.i  = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_o.s  = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  // Branch offset, bit 0 implied zero
  assign imm_o.sb = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                     instr_i[11:8], 1'b0};
  assign imm_o.u  = {instr_i[31:12], 12'b0};
  assign imm_o.uj = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

  //////////////////////////////////////////////////
  // Opcode decode
  //////////////////////////////////////////////////

  always_comb begin : decode
    // Defaults describe a no-op
    dec              = '0;
    dec.alu_operator = ALU_SLTU;
    dec.bch_jmp_sel  = BJ_BCH;
    dec.rf_waddr     = rd;
    illegal          = 1'b0;

    case (opcode)
      OPC_OP: begin
        dec.alu_en   = 1'b1;
        dec.op_a_sel = OPA_REG;
        dec.op_b_sel = OPB_REG;
        dec.rf_re    = 2'b11;
        dec.rf_we    = (rd != '0);
        // Only funct7 0x00 and 0x20 exist in the base set
        case ({funct7, funct3})
          {7'h00, 3'b000}: dec.alu_operator = ALU_ADD;
          {7'h20, 3'b000}: dec.alu_operator = ALU_SUB;
          {7'h00, 3'b001}: dec.alu_operator = ALU_SLL;
          {7'h00, 3'b010}: dec.alu_operator = ALU_SLT;
          {7'h00, 3'b011}: dec.alu_operator = ALU_SLTU;
          {7'h00, 3'b100}: dec.alu_operator = ALU_XOR;
          {7'h00, 3'b101}: dec.alu_operator = ALU_SRL;
          {7'h20, 3'b101}: dec.alu_operator = ALU_SRA;
          {7'h00, 3'b110}: dec.alu_operator = ALU_OR;
          {7'h00, 3'b111}: dec.alu_operator = ALU_AND;
          default:         illegal = 1'b1;
        endcase
      end

      OPC_OPIMM: begin
        dec.alu_en    = 1'b1;
        dec.op_a_sel  = OPA_REG;
        dec.op_b_sel  = OPB_IMM;
        dec.imm_b_sel = IMMB_I;
        dec.rf_re     = 2'b01;
        dec.rf_we     = (rd != '0);
        case (funct3)
          3'b000: dec.alu_operator = ALU_ADD;
          3'b010: dec.alu_operator = ALU_SLT;
          3'b011: dec.alu_operator = ALU_SLTU;
          3'b100: dec.alu_operator = ALU_XOR;
          3'b110: dec.alu_operator = ALU_OR;
          3'b111: dec.alu_operator = ALU_AND;
          3'b001: begin
            dec.alu_operator = ALU_SLL;
            illegal          = (funct7 != 7'h00);
          end
          default: begin
            // Shift right, bit 30 picks arithmetic
            dec.alu_operator = funct7[5] ? ALU_SRA : ALU_SRL;
            illegal          = ({funct7[6], funct7[4:0]} != 6'b0);
          end
        endcase
      end

      OPC_LUI, OPC_AUIPC: begin
        dec.alu_en       = 1'b1;
        dec.alu_operator = ALU_ADD;
        dec.op_a_sel     = (opcode == OPC_LUI) ? OPA_ZERO : OPA_PC;
        dec.op_b_sel     = OPB_IMM;
        dec.imm_b_sel    = IMMB_U;
        dec.rf_we        = (rd != '0);
      end

      OPC_JAL, OPC_JALR: begin
        // ALU forms the link value pc + 4
        dec.alu_en       = 1'b1;
        dec.alu_jmp      = 1'b1;
        dec.alu_operator = ALU_ADD;
        dec.op_a_sel     = OPA_PC;
        dec.op_b_sel     = OPB_IMM;
        dec.imm_b_sel    = IMMB_PCINCR;
        dec.rf_we        = (rd != '0);
        if (opcode == OPC_JALR) begin
          dec.bch_jmp_sel = BJ_JALR;
          dec.rf_re       = 2'b01;
          illegal         = (funct3 != 3'b000);
        end else begin
          dec.bch_jmp_sel = BJ_JAL;
        end
      end

      OPC_BRANCH: begin
        dec.alu_en      = 1'b1;
        dec.alu_bch     = 1'b1;
        dec.op_a_sel    = OPA_REG;
        dec.op_b_sel    = OPB_REG;
        dec.op_c_sel    = OPC_BCH;
        dec.bch_jmp_sel = BJ_BCH;
        dec.rf_re       = 2'b11;
        case (funct3)
          3'b000:  dec.alu_operator = ALU_EQ;
          3'b001:  dec.alu_operator = ALU_NE;
          3'b100:  dec.alu_operator = ALU_LT;
          3'b101:  dec.alu_operator = ALU_GE;
          3'b110:  dec.alu_operator = ALU_LTU;
          3'b111:  dec.alu_operator = ALU_GEU;
          default: illegal = 1'b1;
        endcase
      end

      default: illegal = 1'b1;
    endcase

    // Unknown encodings leave with every enable low
    if (illegal) begin
      dec              = '0;
      dec.alu_operator = ALU_SLTU;
      dec.bch_jmp_sel  = BJ_BCH;
      dec.rf_waddr     = rd;
      dec.illegal_insn = 1'b1;
    end
  end

  assign dec_o = dec;

endmodule

// File: src/id_operand_sel.sv
//////////////////////////////////////////////////
// Operand selection for the ID stage
// Forwarding muxes for rs1, rs2 and the JALR base,
// then the A/B/C operand muxes feeding ID/EX
//////////////////////////////////////////////////
`timescale 1ns/100ps

module id_operand_sel (
  input  id_pkg::dec_ctrl_t dec_i,
  input  id_pkg::imm_set_t  imm_i,
  input  id_pkg::data_t     pc_i,
  input  id_pkg::data_t     bch_target_i,
  input  id_pkg::data_t     rf_rdata_i [2],
  input  id_pkg::data_t     rf_wdata_ex_i,
  input  id_pkg::data_t     rf_wdata_wb_i,
  input  id_pkg::ctrl_byp_t ctrl_byp_i,
  output id_pkg::operands_t operands_o
);
  import id_pkg::*;

  data_t op_a_fw;
  data_t op_b_fw;
  data_t jalr_fw;
  data_t imm_b;
  data_t op_a;
  data_t op_b;
  data_t op_c;

  //////////////////////////////////////////////////
  // Forwarding
  //////////////////////////////////////////////////

  always_comb begin : op_a_fw_mux
    case (ctrl_byp_i.op_a_fw_sel)
      FW_EX:   op_a_fw = rf_wdata_ex_i;
      FW_WB:   op_a_fw = rf_wdata_wb_i;
      default: op_a_fw = rf_rdata_i[0];
    endcase
  end

  always_comb begin : op_b_fw_mux
    case (ctrl_byp_i.op_b_fw_sel)
      FW_EX:   op_b_fw = rf_wdata_ex_i;
      FW_WB:   op_b_fw = rf_wdata_wb_i;
      default: op_b_fw = rf_rdata_i[1];
    endcase
  end

  // JALR base, EX hazards are stalled by the controller
  assign jalr_fw = (ctrl_byp_i.jalr_fw_sel == JFW_WB) ? rf_wdata_wb_i : rf_rdata_i[0];

  //////////////////////////////////////////////////
  // Operand muxes
  //////////////////////////////////////////////////

  always_comb begin : op_a_mux
    case (dec_i.op_a_sel)
      OPA_PC:   op_a = pc_i;
      OPA_ZERO: op_a = '0;
      default:  op_a = op_a_fw;
    endcase
  end

  always_comb begin : imm_b_mux
    case (dec_i.imm_b_sel)
      IMMB_S:      imm_b = imm_i.s;
      IMMB_U:      imm_b = imm_i.u;
      IMMB_PCINCR: imm_b = data_t'(PC_INCR);
      default:     imm_b = imm_i.i;
    endcase
  end

  assign op_b = (dec_i.op_b_sel == OPB_IMM) ? imm_b : op_b_fw;

  // Branches carry their target to EX on operand C
  assign op_c = (dec_i.op_c_sel == OPC_BCH) ? bch_target_i : op_b_fw;

  assign operands_o.operand_a = op_a;
  assign operands_o.operand_b = op_b;
  assign operands_o.operand_c = op_c;
  assign operands_o.jalr_fw   = jalr_fw;

endmodule

// File: src/id_pc_target.sv
//////////////////////////////////////////////////
// Branch and jump target adders
// JALR path sits behind the forwarding mux and
// sets the critical timing of the stage
//////////////////////////////////////////////////
`timescale 1ns/100ps

module id_pc_target (
  input  id_pkg::data_t        pc_i,
  input  id_pkg::imm_set_t     imm_i,
  input  id_pkg::bch_jmp_sel_e bch_jmp_sel_i,
  input  id_pkg::data_t        jalr_fw_i,
  output id_pkg::data_t        bch_target_o,
  output id_pkg::data_t        jmp_target_o
);
  import id_pkg::*;

  data_t jalr_sum;

  // Branch target, resolved later in EX
  assign bch_target_o = pc_i + imm_i.sb;

  // Register relative jump
  assign jalr_sum = jalr_fw_i + imm_i.i;

  always_comb begin : jmp_target_mux
    case (bch_jmp_sel_i)
      BJ_JAL:  jmp_target_o = pc_i + imm_i.uj;
      // LSB always cleared for JALR
      BJ_JALR: jmp_target_o = {jalr_sum[XLEN-1:1], 1'b0};
      default: jmp_target_o = bch_target_o;
    endcase
  end

endmodule

// File: src/id_ex_pipe_reg.sv
//////////////////////////////////////////////////
// ID/EX pipeline register
// Loads on a transfer, drops valid on a bubble,
// holds everything under back-pressure
//////////////////////////////////////////////////
`timescale 1ns/100ps

module id_ex_pipe_reg (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                transfer_i,
  input  logic                ex_ready_i,
  input  id_pkg::dec_ctrl_t   dec_i,
  input  id_pkg::operands_t   ops_i,
  input  id_pkg::if_id_pipe_t if_id_pipe_i,
  output id_pkg::id_ex_pipe_t id_ex_pipe_o
);
  import id_pkg::*;

  always_ff @(posedge clk or negedge rst_n) begin : id_ex_regs
    if (!rst_n) begin
      id_ex_pipe_o              <= '0;
      id_ex_pipe_o.alu_operator <= ALU_SLTU;
    end else begin
      if (transfer_i) begin
        //////////////////////////////////////////////////
        // Fields loaded on every transfer
        //////////////////////////////////////////////////
        id_ex_pipe_o.instr_valid  <= 1'b1;
        id_ex_pipe_o.alu_en       <= dec_i.alu_en;
        id_ex_pipe_o.rf_we        <= dec_i.rf_we;
        id_ex_pipe_o.illegal_insn <= dec_i.illegal_insn;
        id_ex_pipe_o.pc           <= if_id_pipe_i.pc;
        id_ex_pipe_o.instr        <= if_id_pipe_i.instr;

        // Operands only toggle when used
        if (dec_i.op_a_sel != OPA_NONE) begin
          id_ex_pipe_o.alu_operand_a <= ops_i.operand_a;
        end
        if (dec_i.op_b_sel != OPB_NONE) begin
          id_ex_pipe_o.alu_operand_b <= ops_i.operand_b;
        end
        if (dec_i.op_c_sel != OPC_NONE) begin
          id_ex_pipe_o.operand_c <= ops_i.operand_c;
        end

        // ALU detail gated by its enable
        if (dec_i.alu_en) begin
          id_ex_pipe_o.alu_bch      <= dec_i.alu_bch;
          id_ex_pipe_o.alu_jmp      <= dec_i.alu_jmp;
          id_ex_pipe_o.alu_operator <= dec_i.alu_operator;
        end

        if (dec_i.rf_we) begin
          id_ex_pipe_o.rf_waddr <= dec_i.rf_waddr;
        end
      end else if (ex_ready_i) begin
        // EX drained, nothing new from ID
        id_ex_pipe_o.instr_valid <= 1'b0;
      end
    end
  end

endmodule

// File: src/id_stage.sv
//////////////////////////////////////////////////
// Instruction decode stage of the RV32I core
// Decodes the IF/ID word, reads and forwards
// operands, forms the jump target and hands the
// result to EX through the ID/EX register
//////////////////////////////////////////////////
`timescale 1ns/100ps

module id_stage (
  input  logic                clk,
  input  logic                rst_n,
  input  id_pkg::if_id_pipe_t if_id_pipe_i,
  input  id_pkg::ctrl_byp_t   ctrl_byp_i,
  input  id_pkg::ctrl_fsm_t   ctrl_fsm_i,
  input  id_pkg::data_t       rf_rdata_i [2],
  input  id_pkg::data_t       rf_wdata_ex_i,
  input  id_pkg::data_t       rf_wdata_wb_i,
  input  logic                ex_ready_i,
  output id_pkg::rf_addr_t    rf_raddr_o [2],
  output logic [1:0]          rf_re_o,
  output id_pkg::data_t       jmp_target_o,
  output id_pkg::id_ex_pipe_t id_ex_pipe_o,
  output logic                id_ready_o,
  output logic                id_valid_o
);
  import id_pkg::*;

  dec_ctrl_t dec;
  imm_set_t  imm;
  operands_t ops;
  data_t     bch_target;
  logic      instr_valid;
  logic      transfer;

  //////////////////////////////////////////////////
  // Register file read side
  //////////////////////////////////////////////////

  assign rf_raddr_o[0] = if_id_pipe_i.instr[REG_S1_MSB:REG_S1_LSB];
  assign rf_raddr_o[1] = if_id_pipe_i.instr[REG_S2_MSB:REG_S2_LSB];
  assign rf_re_o       = dec.rf_re;

  id_decoder i_id_decoder (
    .instr_i (if_id_pipe_i.instr),
    .dec_o   (dec),
    .imm_o   (imm)
  );

  id_pc_target i_id_pc_target (
    .pc_i          (if_id_pipe_i.pc),
    .imm_i         (imm),
    .bch_jmp_sel_i (dec.bch_jmp_sel),
    .jalr_fw_i     (ops.jalr_fw),
    .bch_target_o  (bch_target),
    .jmp_target_o  (jmp_target_o)
  );

  id_operand_sel i_id_operand_sel (
    .dec_i         (dec),
    .imm_i         (imm),
    .pc_i          (if_id_pipe_i.pc),
    .bch_target_i  (bch_target),
    .rf_rdata_i    (rf_rdata_i),
    .rf_wdata_ex_i (rf_wdata_ex_i),
    .rf_wdata_wb_i (rf_wdata_wb_i),
    .ctrl_byp_i    (ctrl_byp_i),
    .operands_o    (ops)
  );

  //////////////////////////////////////////////////
  // Handshake
  //////////////////////////////////////////////////

  // Kill and halt both mask the incoming instruction
  assign instr_valid = if_id_pipe_i.instr_valid && !ctrl_fsm_i.kill_id && !ctrl_fsm_i.halt_id;
  assign id_valid_o  = instr_valid;
  // A killed instruction is dropped, so ID frees up at once
  assign id_ready_o  = ctrl_fsm_i.kill_id || (ex_ready_i && !ctrl_fsm_i.halt_id);
  assign transfer    = id_valid_o && ex_ready_i;

  id_ex_pipe_reg i_id_ex_pipe_reg (
    .clk          (clk),
    .rst_n        (rst_n),
    .transfer_i   (transfer),
    .ex_ready_i   (ex_ready_i),
    .dec_i        (dec),
    .ops_i        (ops),
    .if_id_pipe_i (if_id_pipe_i),
    .id_ex_pipe_o (id_ex_pipe_o)
  );

endmodule

// File: sim/tb_id_vectors.svh
//////////////////////////////////////////////////
// Stimulus and expected values for the ID stage
// testbench, one row per instruction
// Included inside the testbench module body
//////////////////////////////////////////////////
`ifndef TB_ID_VECTORS_SVH
`define TB_ID_VECTORS_SVH

// Operand and target source codes
localparam logic [1:0] A_NONE = 2'd0, A_RS1 = 2'd1, A_PC = 2'd2, A_ZERO = 2'd3;
localparam logic [1:0] B_NONE = 2'd0, B_RS2 = 2'd1, B_IMM = 2'd2, B_INC = 2'd3;
localparam logic [1:0] T_NONE = 2'd0, T_JAL = 2'd1, T_JALR = 2'd2, T_BCH = 2'd3;

// Bypass settings used by the rows
localparam ctrl_byp_t BYP_RF   = '{FW_REGFILE, FW_REGFILE, JFW_REGFILE};
localparam ctrl_byp_t BYP_EXWB = '{FW_EX, FW_WB, JFW_REGFILE};
localparam ctrl_byp_t BYP_AWB  = '{FW_WB, FW_REGFILE, JFW_REGFILE};
localparam ctrl_byp_t BYP_BEX  = '{FW_REGFILE, FW_EX, JFW_REGFILE};
localparam ctrl_byp_t BYP_JWB  = '{FW_REGFILE, FW_REGFILE, JFW_WB};

// ctl is {kill, halt, ex_ready}, en is {alu_en, bch, jmp}, wi is {rf_we, illegal}
// k is the B immediate, or the offset of the jump or branch target
typedef struct packed {
  data_t       instr;
  ctrl_byp_t   byp;
  logic [2:0]  ctl;
  logic [2:0]  en;
  alu_opcode_e op;
  logic [1:0]  a_src;
  logic [1:0]  b_src;
  data_t       k;
  logic [1:0]  tgt;
  logic [1:0]  wi;
} vec_t;

localparam int N_ROWS = 19;

localparam vec_t VECS [N_ROWS] = '{
  // add x3,x1,x2 / sub x5,x6,x7 forwarded / addi x10,x1,-5 from WB
  '{32'h002081b3, BYP_RF, 3'b001, 3'b100, ALU_ADD, A_RS1, B_RS2, 32'h0, T_NONE, 2'b10},
  '{32'h407302b3, BYP_EXWB, 3'b001, 3'b100, ALU_SUB, A_RS1, B_RS2, 32'h0, T_NONE, 2'b10},
  '{32'hffb08513, BYP_AWB, 3'b001, 3'b100, ALU_ADD, A_RS1, B_IMM, 32'hffff_fffb, T_NONE, 2'b10},
  // xori x0 writes nothing, srai x8,x9,3
  '{32'h7ff14013, BYP_RF, 3'b001, 3'b100, ALU_XOR, A_RS1, B_IMM, 32'h0000_07ff, T_NONE, 2'b00},
  '{32'h4034d413, BYP_RF, 3'b001, 3'b100, ALU_SRA, A_RS1, B_IMM, 32'h0000_0403, T_NONE, 2'b10},
  // lui and auipc
  '{32'habcde0b7, BYP_RF, 3'b001, 3'b100, ALU_ADD, A_ZERO, B_IMM, 32'habcd_e000, T_NONE, 2'b10},
  '{32'h12345117, BYP_RF, 3'b001, 3'b100, ALU_ADD, A_PC, B_IMM, 32'h1234_5000, T_NONE, 2'b10},
  // jal +0x800, jal x0 -4, jalr x1 3(x5), jalr x0 -8(x2) with WB base
  '{32'h001000ef, BYP_RF, 3'b001, 3'b101, ALU_ADD, A_PC, B_INC, 32'h0000_0800, T_JAL, 2'b10},
  '{32'hffdff06f, BYP_RF, 3'b001, 3'b101, ALU_ADD, A_PC, B_INC, 32'hffff_fffc, T_JAL, 2'b00},
  '{32'h003280e7, BYP_RF, 3'b001, 3'b101, ALU_ADD, A_PC, B_INC, 32'h0000_0003, T_JALR, 2'b10},
  '{32'hff810067, BYP_JWB, 3'b001, 3'b101, ALU_ADD, A_PC, B_INC, 32'hffff_fff8, T_JALR, 2'b00},
  // beq +16, bgeu -32 with rs2 from EX
  '{32'h00208863, BYP_RF, 3'b001, 3'b110, ALU_EQ, A_RS1, B_RS2, 32'h0000_0010, T_BCH, 2'b00},
  '{32'hfe41f0e3, BYP_BEX, 3'b001, 3'b110, ALU_GEU, A_RS1, B_RS2, 32'hffff_ffe0, T_BCH, 2'b00},
  // ecall and mul are outside the subset
  '{32'h00000073, BYP_RF, 3'b001, 3'b000, ALU_SLTU, A_NONE, B_NONE, 32'h0, T_NONE, 2'b01},
  '{32'h022081b3, BYP_RF, 3'b001, 3'b000, ALU_SLTU, A_NONE, B_NONE, 32'h0, T_NONE, 2'b01},
  // Back-pressure, halt, kill, then add x9,x9,x10 resumes
  '{32'h002081b3, BYP_RF, 3'b000, 3'b100, ALU_ADD, A_RS1, B_RS2, 32'h0, T_NONE, 2'b10},
  '{32'h002081b3, BYP_RF, 3'b011, 3'b100, ALU_ADD, A_RS1, B_RS2, 32'h0, T_NONE, 2'b10},
  '{32'h002081b3, BYP_RF, 3'b101, 3'b100, ALU_ADD, A_RS1, B_RS2, 32'h0, T_NONE, 2'b10},
  '{32'h00a484b3, BYP_EXWB, 3'b001, 3'b100, ALU_ADD, A_RS1, B_RS2, 32'h0, T_NONE, 2'b10}
};

`endif

// File: sim/tb_id_stage.sv
//////////////////////////////////////////////////
// Testbench for the RV32I decode stage
// Applies the vector table row by row with random
// register data and checks outputs and ID/EX
//////////////////////////////////////////////////
`timescale 1ns/100ps

module tb_id_stage;
  import id_pkg::*;

  `include "tb_id_vectors.svh"

  localparam int TIMEOUT_CYCLES = 8 + 4 * N_ROWS + 20;

  logic        clk = 1'b0;
  logic        rst_n;
  if_id_pipe_t if_id_pipe;
  ctrl_byp_t   ctrl_byp;
  ctrl_fsm_t   ctrl_fsm;
  data_t       rf_rdata [2];
  data_t       rf_wdata_ex;
  data_t       rf_wdata_wb;
  logic        ex_ready;
  rf_addr_t    rf_raddr [2];
  logic [1:0]  rf_re;
  data_t       jmp_target;
  id_ex_pipe_t id_ex_pipe;
  logic        id_ready;
  logic        id_valid;

  // Reference model of the ID/EX register
  id_ex_pipe_t exp_pipe;
  integer      seed = 32'h67ef_30d2;
  int          cycles = 0;
  int          checks = 0;
  int          errors = 0;
  int          row_errs = 0;

  always #10 clk = ~clk;

  id_stage i_id_stage (
    .clk           (clk),
    .rst_n         (rst_n),
    .if_id_pipe_i  (if_id_pipe),
    .ctrl_byp_i    (ctrl_byp),
    .ctrl_fsm_i    (ctrl_fsm),
    .rf_rdata_i    (rf_rdata),
    .rf_wdata_ex_i (rf_wdata_ex),
    .rf_wdata_wb_i (rf_wdata_wb),
    .ex_ready_i    (ex_ready),
    .rf_raddr_o    (rf_raddr),
    .rf_re_o       (rf_re),
    .jmp_target_o  (jmp_target),
    .id_ex_pipe_o  (id_ex_pipe),
    .id_ready_o    (id_ready),
    .id_valid_o    (id_valid)
  );

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic check_pipe(input id_ex_pipe_t got, input id_ex_pipe_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      row_errs++;
      $display("mismatch at %0t: ID/EX register got %h expected %h", $time, got, exp);
    end
  endtask

  task automatic check_target(input data_t got, input data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      row_errs++;
      $display("mismatch at %0t: jump target got %h expected %h", $time, got, exp);
    end
  endtask

  // Flags are {id_ready, id_valid}
  task automatic check_flags(input logic [1:0] got, input logic [1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      row_errs++;
      $display("mismatch at %0t: ready/valid got %b expected %b", $time, got, exp);
    end
  endtask

  task automatic check_raddr(input int port, input rf_addr_t got, input rf_addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      row_errs++;
      $display("mismatch at %0t: read address %0d got %0d expected %0d",
               $time, port, got, exp);
    end
  endtask

  // Read enables are {rs2, rs1}
  task automatic check_re(input logic [1:0] got, input logic [1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      row_errs++;
      $display("mismatch at %0t: read enables got %b expected %b", $time, got, exp);
    end
  endtask

  function automatic data_t forwarded(fw_sel_e sel, data_t rf, data_t ex, data_t wb);
    case (sel)
      FW_EX:   return ex;
      FW_WB:   return wb;
      default: return rf;
    endcase
  endfunction

  // Ends a run that stops making progress
  always @(posedge clk) begin : watchdog
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: test did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Checks failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Stimulus loop
  //////////////////////////////////////////////////

  initial begin : stimulus
    vec_t       v;
    data_t      pc;
    data_t      rd0;
    data_t      rd1;
    data_t      ex_d;
    data_t      wb_d;
    data_t      rs1_v;
    data_t      rs2_v;
    data_t      base;
    data_t      exp_tgt;
    logic [1:0] exp_flags;
    logic [1:0] exp_re;
    logic       transfer;

    rst_n       <= 1'b0;
    if_id_pipe  <= '0;
    ctrl_byp    <= '0;
    ctrl_fsm    <= '0;
    rf_rdata[0] <= '0;
    rf_rdata[1] <= '0;
    rf_wdata_ex <= '0;
    rf_wdata_wb <= '0;
    ex_ready    <= 1'b0;
    exp_pipe              = '0;
    exp_pipe.alu_operator = ALU_SLTU;

    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_pipe(id_ex_pipe, exp_pipe);
    $display("reset  : %s", (row_errs == 0) ? "ok" : "FAIL");

    for (int i = 0; i < N_ROWS; i++) begin
      v        = VECS[i];
      pc       = 32'h8000_0100 + 4 * i;
      row_errs = 0;
      rd0      = $random(seed);
      rd1      = $random(seed);
      ex_d     = $random(seed);
      wb_d     = $random(seed);

      @(posedge clk);
      if_id_pipe.instr_valid <= 1'b1;
      if_id_pipe.pc          <= pc;
      if_id_pipe.instr       <= v.instr;
      ctrl_byp               <= v.byp;
      ctrl_fsm.kill_id       <= v.ctl[2];
      ctrl_fsm.halt_id       <= v.ctl[1];
      ex_ready               <= v.ctl[0];
      rf_rdata[0]            <= rd0;
      rf_rdata[1]            <= rd1;
      rf_wdata_ex            <= ex_d;
      rf_wdata_wb            <= wb_d;

      // Expected handshake levels
      transfer  = !v.ctl[2] && !v.ctl[1] && v.ctl[0];
      exp_flags = {v.ctl[2] || (v.ctl[0] && !v.ctl[1]), !v.ctl[2] && !v.ctl[1]};
      // rs1 is read for a register operand A or a JALR base, rs2 for operand B
      exp_re    = {v.b_src == B_RS2, (v.a_src == A_RS1) || (v.tgt == T_JALR)};
      rs1_v     = forwarded(v.byp.op_a_fw_sel, rd0, ex_d, wb_d);
      rs2_v     = forwarded(v.byp.op_b_fw_sel, rd1, ex_d, wb_d);
      base      = (v.byp.jalr_fw_sel == JFW_WB) ? wb_d : rd0;

      // JALR clears bit 0 of the sum
      case (v.tgt)
        T_JALR:  exp_tgt = (base + v.k) & 32'hffff_fffe;
        default: exp_tgt = pc + v.k;
      endcase

      if (transfer) begin
        exp_pipe.instr_valid  = 1'b1;
        exp_pipe.alu_en       = v.en[2];
        exp_pipe.rf_we        = v.wi[1];
        exp_pipe.illegal_insn = v.wi[0];
        exp_pipe.pc           = pc;
        exp_pipe.instr        = v.instr;
        case (v.a_src)
          A_RS1:   exp_pipe.alu_operand_a = rs1_v;
          A_PC:    exp_pipe.alu_operand_a = pc;
          A_ZERO:  exp_pipe.alu_operand_a = '0;
          default: ;
        endcase
        case (v.b_src)
          B_RS2:   exp_pipe.alu_operand_b = rs2_v;
          B_IMM:   exp_pipe.alu_operand_b = v.k;
          B_INC:   exp_pipe.alu_operand_b = 32'd4;
          default: ;
        endcase
        // Only branches carry operand C
        if (v.tgt == T_BCH) begin
          exp_pipe.operand_c = pc + v.k;
        end
        if (v.en[2]) begin
          exp_pipe.alu_bch      = v.en[1];
          exp_pipe.alu_jmp      = v.en[0];
          exp_pipe.alu_operator = v.op;
        end
        if (v.wi[1]) begin
          exp_pipe.rf_waddr = v.instr[11:7];
        end
      end else if (v.ctl[0]) begin
        exp_pipe.instr_valid = 1'b0;
      end

      @(negedge clk);
      check_flags({id_ready, id_valid}, exp_flags);
      check_raddr(0, rf_raddr[0], v.instr[19:15]);
      check_raddr(1, rf_raddr[1], v.instr[24:20]);
      check_re(rf_re, exp_re);
      if (v.tgt != T_NONE) begin
        check_target(jmp_target, exp_tgt);
      end

      // Register result one edge after the transfer
      @(negedge clk);
      check_pipe(id_ex_pipe, exp_pipe);
      $display("row %2d : instr %h pc %h %s", i, v.instr, pc, (row_errs == 0) ? "ok" : "FAIL");
    end

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+sim
src/id_pkg.sv
src/id_decoder.sv
src/id_operand_sel.sv
src/id_pc_target.sv
src/id_ex_pipe_reg.sv
src/id_stage.sv
sim/tb_id_stage.sv
